// ==== logic/fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// byte address and data beat widths
`define FETCH_ADDR_WIDTH 32
`define FETCH_WORD_WIDTH 32

// words in one cache line
`define FETCH_LINE_WORDS 4

// memory holds 2**FETCH_MEM_LINES_LOG2 lines
`define FETCH_MEM_LINES_LOG2 6

// cycles from read strobe to valid pulse
`define FETCH_MEM_LATENCY 2

// word index into the whole memory, used by the load port
`define FETCH_WORD_INDEX_WIDTH (`FETCH_MEM_LINES_LOG2 + $clog2(`FETCH_LINE_WORDS))

`endif

// ==== logic/fetch_pkg.sv ====
`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

    // one line, word 0 in the lowest bits
    typedef logic [`FETCH_LINE_WORDS-1:0][`FETCH_WORD_WIDTH-1:0] line_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

    // read-address channel payload
    typedef struct packed {
        logic [`FETCH_ADDR_WIDTH-1:0] araddr;
        logic [7:0]                   arlen;
    } axi_ar_t;

    // read-data channel payload
    typedef struct packed {
        logic [`FETCH_WORD_WIDTH-1:0] rdata;
        axi_resp_t                    rresp;
        logic                         rlast;
    } axi_r_t;

    typedef enum logic [1:0] {
        M_IDLE,
        M_ADDR,
        M_DATA
    } master_state_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,
        S_WAIT_MEM,
        S_DATA,
        S_DONE
    } slave_state_t;

endpackage

`default_nettype wire

// ==== logic/line_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_defs.svh"

module line_mem (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               wr_en,
    input  logic [`FETCH_WORD_INDEX_WIDTH-1:0] wr_addr,
    input  logic [`FETCH_WORD_WIDTH-1:0]       wr_data,
    input  logic                               rd_req,
    input  logic [`FETCH_MEM_LINES_LOG2-1:0]   rd_index,
    output logic                               rd_valid,
    output fetch_pkg::line_t                   rd_line
);
    import fetch_pkg::*;

    localparam int LW_LOG2   = $clog2(`FETCH_LINE_WORDS);
    localparam int MEM_LINES = 1 << `FETCH_MEM_LINES_LOG2;
    localparam int LAT       = `FETCH_MEM_LATENCY;

    line_t mem [MEM_LINES];

    logic [LAT-1:0]                   vld_pipe;
    logic [`FETCH_MEM_LINES_LOG2-1:0] idx_pipe [LAT];

    logic [`FETCH_MEM_LINES_LOG2-1:0] wr_line;
    logic [LW_LOG2-1:0]               wr_word;

    assign wr_line = wr_addr[`FETCH_WORD_INDEX_WIDTH-1:LW_LOG2];
    assign wr_word = wr_addr[LW_LOG2-1:0];

    // word write into its line
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_line][wr_word] <= wr_data;
        end
    end

    // valid strobe travels down the delay line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= rd_req;
            for (int i = 1; i < LAT; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    // index follows alongside
    always_ff @(posedge clk) begin
        idx_pipe[0] <= rd_index;
        for (int i = 1; i < LAT; i++) begin
            idx_pipe[i] <= idx_pipe[i-1];
        end
    end

    // array read at the last stage
    assign rd_valid = vld_pipe[LAT-1];
    assign rd_line  = mem[idx_pipe[LAT-1]];

endmodule

`default_nettype wire

// ==== logic/axi_read_slave.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_defs.svh"

module axi_read_slave (
    input  logic                             clk,
    input  logic                             rst_n,
    input  fetch_pkg::axi_ar_t               ar,
    input  logic                             arvalid,
    output logic                             arready,
    output fetch_pkg::axi_r_t                r,
    output logic                             rvalid,
    input  logic                             rready,
    output logic                             mem_rd_req,
    output logic [`FETCH_MEM_LINES_LOG2-1:0] mem_rd_index,
    input  logic                             mem_rd_valid,
    input  fetch_pkg::line_t                 mem_rd_line
);
    import fetch_pkg::*;

    localparam int LW_LOG2  = $clog2(`FETCH_LINE_WORDS);
    localparam int LINE_OFF = $clog2(`FETCH_LINE_WORDS * `FETCH_WORD_WIDTH / 8);
    localparam int IDX_TOP  = LINE_OFF + `FETCH_MEM_LINES_LOG2;

    slave_state_t state, next_state;

    logic [`FETCH_ADDR_WIDTH-1:0] addr_q;
    logic [7:0]                   arlen_q;
    logic [7:0]                   beat_cnt;
    logic                         addr_err;
    line_t                        line_buf;
    logic                         beat_fire;
    logic                         last_beat;

    assign beat_fire = rvalid && rready;
    assign last_beat = (beat_cnt == arlen_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: begin
                if (arvalid) begin
                    next_state = S_ADDR;
                end
            end
            S_ADDR: begin
                // out-of-range lines skip the memory entirely
                next_state = addr_err ? S_DATA : S_WAIT_MEM;
            end
            S_WAIT_MEM: begin
                if (mem_rd_valid) begin
                    next_state = S_DATA;
                end
            end
            S_DATA: begin
                if (beat_fire && last_beat) begin
                    next_state = S_DONE;
                end
            end
            S_DONE: begin
                next_state = S_IDLE;
            end
            default: begin
                next_state = S_IDLE;
            end
        endcase
    end

    // request capture
    always_ff @(posedge clk) begin
        if (state == S_IDLE && arvalid) begin
            addr_q  <= ar.araddr;
            arlen_q <= ar.arlen;
        end
    end

    // any address bit above the memory range flags an error
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_err <= 1'b0;
        end else if (state == S_IDLE && arvalid) begin
            addr_err <= (ar.araddr[`FETCH_ADDR_WIDTH-1:IDX_TOP] != '0);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (state == S_IDLE) begin
            beat_cnt <= '0;
        end else if (beat_fire && !last_beat) begin
            beat_cnt <= beat_cnt + 8'd1;
        end
    end

    // line buffer, zeros for a bad address
    always_ff @(posedge clk) begin
        if (state == S_ADDR && addr_err) begin
            line_buf <= '0;
        end else if (state == S_WAIT_MEM && mem_rd_valid) begin
            line_buf <= mem_rd_line;
        end
    end

    assign mem_rd_req   = (state == S_ADDR) && !addr_err;
    assign mem_rd_index = addr_q[IDX_TOP-1:LINE_OFF];

    assign arready = (state == S_IDLE);

    assign rvalid  = (state == S_DATA);
    assign r.rdata = line_buf[beat_cnt[LW_LOG2-1:0]];
    assign r.rresp = addr_err ? RESP_SLVERR : RESP_OKAY;
    assign r.rlast = last_beat;

    // master must hold the address while it waits
    a_ar_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar)
    ) else $error("ar changed while arvalid was waiting for arready");

endmodule

`default_nettype wire

// ==== logic/line_read_master.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_defs.svh"

module line_read_master (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req_valid,
    input  logic [`FETCH_ADDR_WIDTH-1:0] req_addr,
    output logic                         busy,
    output logic                         resp_valid,
    output fetch_pkg::line_t             resp_line,
    output logic                         resp_err,
    output fetch_pkg::axi_ar_t           ar,
    output logic                         arvalid,
    input  logic                         arready,
    input  fetch_pkg::axi_r_t            r,
    input  logic                         rvalid,
    output logic                         rready
);
    import fetch_pkg::*;

    localparam int LW_LOG2  = $clog2(`FETCH_LINE_WORDS);
    localparam int LINE_OFF = $clog2(`FETCH_LINE_WORDS * `FETCH_WORD_WIDTH / 8);
    localparam logic [LW_LOG2-1:0] LAST_BEAT = LW_LOG2'(`FETCH_LINE_WORDS - 1);

    master_state_t state, next_state;

    logic [`FETCH_ADDR_WIDTH-1:0] addr_q;
    logic [LW_LOG2-1:0]           beat_cnt;
    line_t                        line_q;
    logic                         err_q;
    logic                         accept;
    logic                         beat_fire;

    assign accept    = (state == M_IDLE) && req_valid;
    assign beat_fire = rvalid && rready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= M_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            M_IDLE: begin
                if (req_valid) begin
                    next_state = M_ADDR;
                end
            end
            M_ADDR: begin
                if (arready) begin
                    next_state = M_DATA;
                end
            end
            M_DATA: begin
                if (beat_fire && r.rlast) begin
                    next_state = M_IDLE;
                end
            end
            default: begin
                next_state = M_IDLE;
            end
        endcase
    end

    // fetch the whole line containing the request
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= {req_addr[`FETCH_ADDR_WIDTH-1:LINE_OFF], LINE_OFF'(0)};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (accept) begin
            beat_cnt <= '0;
        end else if (beat_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // reassembly
    always_ff @(posedge clk) begin
        if (beat_fire) begin
            line_q[beat_cnt] <= r.rdata;
        end
    end

    // sticky over the burst
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_q <= 1'b0;
        end else if (accept) begin
            err_q <= 1'b0;
        end else if (beat_fire && r.rresp != RESP_OKAY) begin
            err_q <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= (state == M_DATA) && beat_fire && r.rlast;
        end
    end

    assign ar.araddr = addr_q;
    assign ar.arlen  = 8'(`FETCH_LINE_WORDS - 1);
    assign arvalid   = (state == M_ADDR);
    assign rready    = (state == M_DATA);

    assign busy      = (state != M_IDLE) || resp_valid;
    assign resp_line = line_q;
    assign resp_err  = err_q;

    // slave must end the burst exactly on our final word
    a_rlast_on_final: assert property (
        @(posedge clk) disable iff (!rst_n)
        rvalid |-> (r.rlast == (beat_cnt == LAST_BEAT))
    ) else $error("rlast does not line up with the final beat");

    a_beat_in_data: assert property (
        @(posedge clk) disable iff (!rst_n)
        rvalid |-> (state == M_DATA)
    ) else $error("read beat outside of the data phase");

endmodule

`default_nettype wire

// ==== logic/line_fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_defs.svh"

module line_fetch_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               req_valid,
    input  logic [`FETCH_ADDR_WIDTH-1:0]       req_addr,
    output logic                               busy,
    output logic                               resp_valid,
    output fetch_pkg::line_t                   resp_line,
    output logic                               resp_err,
    input  logic                               wr_en,
    input  logic [`FETCH_WORD_INDEX_WIDTH-1:0] wr_addr,
    input  logic [`FETCH_WORD_WIDTH-1:0]       wr_data
);
    import fetch_pkg::*;

    // read-address channel
    axi_ar_t ar;
    logic    arvalid;
    logic    arready;

    // read-data channel
    axi_r_t  r;
    logic    rvalid;
    logic    rready;

    // memory port
    logic                             mem_rd_req;
    logic [`FETCH_MEM_LINES_LOG2-1:0] mem_rd_index;
    logic                             mem_rd_valid;
    line_t                            mem_rd_line;

    line_read_master i_line_read_master (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .busy       (busy),
        .resp_valid (resp_valid),
        .resp_line  (resp_line),
        .resp_err   (resp_err),
        .ar         (ar),
        .arvalid    (arvalid),
        .arready    (arready),
        .r          (r),
        .rvalid     (rvalid),
        .rready     (rready)
    );

    axi_read_slave i_axi_read_slave (
        .clk          (clk),
        .rst_n        (rst_n),
        .ar           (ar),
        .arvalid      (arvalid),
        .arready      (arready),
        .r            (r),
        .rvalid       (rvalid),
        .rready       (rready),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_index (mem_rd_index),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_line  (mem_rd_line)
    );

    line_mem i_line_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_req   (mem_rd_req),
        .rd_index (mem_rd_index),
        .rd_valid (mem_rd_valid),
        .rd_line  (mem_rd_line)
    );

endmodule

`default_nettype wire

// ==== sim/line_fetch_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_defs.svh"

module line_fetch_tb;
    import fetch_pkg::*;

    localparam int LINE_WORDS  = `FETCH_LINE_WORDS;
    localparam int LINE_BYTES  = LINE_WORDS * `FETCH_WORD_WIDTH / 8;
    localparam int LINE_OFF    = $clog2(LINE_BYTES);
    localparam int MEM_LINES   = 1 << `FETCH_MEM_LINES_LOG2;
    localparam int MEM_WORDS   = MEM_LINES * LINE_WORDS;
    localparam int MEM_BYTES   = MEM_LINES * LINE_BYTES;
    localparam int FETCH_LIMIT = LINE_WORDS + `FETCH_MEM_LATENCY + 10;
    localparam int FETCH_COUNT = 10;
    localparam int WATCHDOG_CYCLES = FETCH_COUNT * FETCH_LIMIT + MEM_WORDS + 64;

    logic                               clk;
    logic                               rst_n;
    logic                               req_valid;
    logic [`FETCH_ADDR_WIDTH-1:0]       req_addr;
    logic                               busy;
    logic                               resp_valid;
    line_t                              resp_line;
    logic                               resp_err;
    logic                               wr_en;
    logic [`FETCH_WORD_INDEX_WIDTH-1:0] wr_addr;
    logic [`FETCH_WORD_WIDTH-1:0]       wr_data;

    logic [`FETCH_WORD_WIDTH-1:0] mirror [MEM_WORDS];
    int seed;
    int error_count;
    int resp_count;

    line_fetch_top i_line_fetch_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .busy       (busy),
        .resp_valid (resp_valid),
        .resp_line  (resp_line),
        .resp_err   (resp_err),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // responses seen mid-cycle
    always @(negedge clk) begin
        if (rst_n && resp_valid) begin
            resp_count++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    task automatic check_line(input string test, input line_t exp, input line_t act);
        if (act !== exp) begin
            error_count++;
            $display("[FAIL] %s: expected %h, actual %h", test, exp, act);
        end
    endtask

    task automatic check_flag(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            error_count++;
            $display("[FAIL] %s: expected %b, actual %b", test, exp, act);
        end
    endtask

    task automatic check_count(input string test, input int exp, input int act);
        if (act != exp) begin
            error_count++;
            $display("[FAIL] %s: expected %0d, actual %0d", test, exp, act);
        end
    endtask

    // zeros for lines outside the memory
    function automatic line_t expected_line(input logic [`FETCH_ADDR_WIDTH-1:0] addr);
        line_t line;
        int    base;
        line = '0;
        if (addr < MEM_BYTES) begin
            base = int'(addr >> LINE_OFF) * LINE_WORDS;
            for (int w = 0; w < LINE_WORDS; w++) begin
                line[w] = mirror[base + w];
            end
        end
        return line;
    endfunction

    task automatic write_word(input int index, input logic [`FETCH_WORD_WIDTH-1:0] data);
        @(posedge clk);
        #2;
        wr_en   = 1'b1;
        wr_addr = index[`FETCH_WORD_INDEX_WIDTH-1:0];
        wr_data = data;
        mirror[index] = data;
    endtask

    task automatic load_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            write_word(i, $random(seed));
        end
        @(posedge clk);
        #2;
        wr_en = 1'b0;
    endtask

    task automatic wait_response(input string test, output line_t line, output logic err,
                                 output bit ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < FETCH_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (resp_valid) begin
                ok   = 1'b1;
                line = resp_line;
                err  = resp_err;
            end
        end
        if (!ok) begin
            error_count++;
            $display("%s: no response came within %0d cycles", test, FETCH_LIMIT);
        end
    endtask

    task automatic fetch_and_check(input string test, input logic [`FETCH_ADDR_WIDTH-1:0] addr,
                                   input logic exp_err);
        line_t line;
        logic  err;
        bit    ok;
        @(posedge clk);
        #2;
        req_valid = 1'b1;
        req_addr  = addr;
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        // request taken at the last edge
        check_flag({test, " busy"}, 1'b1, busy);
        wait_response(test, line, err, ok);
        if (ok) begin
            check_line(test, expected_line(addr), line);
            check_flag({test, " err"}, exp_err, err);
            @(negedge clk);
            check_flag({test, " pulse"}, 1'b0, resp_valid);
            check_flag({test, " busy after"}, 1'b0, busy);
        end
    endtask

    task automatic test_idle_after_reset();
        repeat (8) begin
            @(negedge clk);
            check_flag("idle busy", 1'b0, busy);
            check_flag("idle resp_valid", 1'b0, resp_valid);
        end
    endtask

    task automatic test_aligned_fetches();
        fetch_and_check("aligned line 0", 32'h0000_0000, 1'b0);
        fetch_and_check("aligned line 1", 32'h0000_0010, 1'b0);
        fetch_and_check("aligned line 37", 32'(37 * LINE_BYTES), 1'b0);
        fetch_and_check("aligned last line", 32'((MEM_LINES - 1) * LINE_BYTES), 1'b0);
    endtask

    task automatic test_unaligned_fetch();
        fetch_and_check("unaligned line 9", 32'(9 * LINE_BYTES + 6), 1'b0);
    endtask

    task automatic test_out_of_range();
        fetch_and_check("out of range", 32'(MEM_BYTES), 1'b1);
        fetch_and_check("after out of range", 32'(12 * LINE_BYTES), 1'b0);
    endtask

    // second fetch begins only when the master returns to idle
    task automatic test_held_request();
        line_t line;
        logic  err;
        bit    ok;
        int    count_before;
        logic [`FETCH_ADDR_WIDTH-1:0] addr_a;
        logic [`FETCH_ADDR_WIDTH-1:0] addr_b;
        addr_a       = 32'(20 * LINE_BYTES);
        addr_b       = 32'(41 * LINE_BYTES + 12);
        count_before = resp_count;
        @(posedge clk);
        #2;
        req_valid = 1'b1;
        req_addr  = addr_a;
        // first request taken at this edge
        @(posedge clk);
        #2;
        req_addr = addr_b;
        wait_response("held first", line, err, ok);
        if (ok) begin
            check_line("held first", expected_line(addr_a), line);
            check_flag("held first err", 1'b0, err);
        end
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        wait_response("held second", line, err, ok);
        if (ok) begin
            check_line("held second", expected_line(addr_b), line);
            check_flag("held second err", 1'b0, err);
        end
        repeat (6) @(negedge clk);
        check_count("held response count", 2, resp_count - count_before);
        check_flag("held busy after", 1'b0, busy);
    endtask

    task automatic test_overwrite_word();
        write_word(5 * LINE_WORDS + 2, 32'hcafe_f00d);
        @(posedge clk);
        #2;
        wr_en = 1'b0;
        fetch_and_check("overwrite line 5", 32'(5 * LINE_BYTES), 1'b0);
    endtask

    initial begin
        seed        = 96;
        error_count = 0;
        resp_count  = 0;
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req_addr    = '0;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_idle_after_reset();
        load_memory();
        test_aligned_fetches();
        test_unaligned_fetch();
        test_out_of_range();
        test_held_request();
        test_overwrite_word();

        repeat (2) @(posedge clk);
        $display("line_fetch_tb done, %0d errors", error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+logic
logic/fetch_pkg.sv
logic/line_mem.sv
logic/axi_read_slave.sv
logic/line_read_master.sv
logic/line_fetch_top.sv
sim/line_fetch_tb.sv
